// File: axi_ram.f
hdl/axi_ram_pkg.sv
hdl/lane_bank.sv
hdl/axi_wr_ctrl.sv
hdl/axi_rd_ctrl.sv
hdl/axi_ram_top.sv
verif/axi_ram_tb.sv

// File: hdl/axi_ram_pkg.sv
`default_nettype none

package axi_ram_pkg;

  // AXI4 bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // AxBURST encodings
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10,
    burst_rsvd  = 2'b11
  } burst_e;

  // xRESP encodings
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,   // taking W beats
    wr_resp    // holding B until bready
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_fetch,  // bank read in flight
    rd_beat,   // presenting a non-final beat
    rd_done    // presenting the final beat
  } rd_state_e;

endpackage

`default_nettype wire

// File: hdl/axi_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_top
  import axi_ram_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic              clock,
  input  logic              rst_n,
  // write address
  input  logic              awvalid,
  output logic              awready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic [ID_W-1:0]   awid,
  input  logic [7:0]        awlen,
  input  logic [2:0]        awsize,
  input  logic [1:0]        awburst,
  // write data
  input  logic              wvalid,
  output logic              wready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wlast,   // beats are counted from awlen
  // write response
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  output logic [ID_W-1:0]   bid,
  // read address
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic [ID_W-1:0]   arid,
  input  logic [7:0]        arlen,
  input  logic [2:0]        arsize,
  input  logic [1:0]        arburst,
  // read data
  output logic              rvalid,
  input  logic              rready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rlast,
  output logic [ID_W-1:0]   rid
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [IDX_W-1:0]  wr_index;
  logic [STRB_W-1:0] lane_we;
  logic [DATA_W-1:0] lane_wdata;
  logic              rd_en;
  logic [IDX_W-1:0]  rd_index;
  logic [DATA_W-1:0] lane_rdata;

  axi_wr_ctrl #(.MEM_WORDS(MEM_WORDS)) axi_wr_ctrl_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awid       (awid),
    .awlen      (awlen),
    .awsize     (awsize),
    .awburst    (awburst),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .bid        (bid),
    .wr_index   (wr_index),
    .lane_we    (lane_we),
    .lane_wdata (lane_wdata)
  );

  // one byte-wide bank per lane
  for (genvar g = 0; g < STRB_W; g++) begin : g_lane
    lane_bank #(.MEM_WORDS(MEM_WORDS)) lane_bank_i (
      .clock    (clock),
      .we       (lane_we[g]),
      .wr_index (wr_index),
      .wdata    (lane_wdata[8*g +: 8]),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .rdata    (lane_rdata[8*g +: 8])
    );
  end

  axi_rd_ctrl #(.MEM_WORDS(MEM_WORDS)) axi_rd_ctrl_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .arid       (arid),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast),
    .rid        (rid),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .lane_rdata (lane_rdata)
  );

endmodule

`default_nettype wire

// File: hdl/axi_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_ctrl
  import axi_ram_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         arvalid,
  output logic                         arready,
  input  logic [ADDR_W-1:0]            araddr,
  input  logic [ID_W-1:0]              arid,
  input  logic [7:0]                   arlen,
  input  logic [2:0]                   arsize,
  input  logic [1:0]                   arburst,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [DATA_W-1:0]            rdata,
  output logic [1:0]                   rresp,
  output logic                         rlast,
  output logic [ID_W-1:0]              rid,
  output logic                         rd_en,
  output logic [$clog2(MEM_WORDS)-1:0] rd_index,
  input  logic [DATA_W-1:0]            lane_rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  rd_state_e         state;
  logic [ADDR_W-1:0] addr_q;
  logic [ID_W-1:0]   id_q;
  logic [7:0]        len_q;
  logic [2:0]        size_q;
  burst_e            burst_q;
  logic [7:0]        beat_cnt;
  logic              burst_ok;
  logic              ar_fire;
  logic              beat_taken;

  assign ar_fire    = arvalid && arready;
  assign beat_taken = rvalid && rready;
  assign burst_ok   = (burst_q == burst_fixed) || (burst_q == burst_incr);

  // one bank read per beat, skipped for unsupported bursts
  assign rd_en    = (state == rd_fetch) && burst_ok;
  assign rd_index = addr_q[3 +: IDX_W];

  // bank outputs stay put while rd_en is low
  assign rvalid = (state == rd_beat) || (state == rd_done);
  assign rlast  = (state == rd_done);
  assign rdata  = burst_ok ? lane_rdata : '0;
  assign rresp  = burst_ok ? resp_okay : resp_slverr;
  assign rid    = id_q;

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      addr_q  <= araddr;
      id_q    <= arid;
      len_q   <= arlen;
      size_q  <= arsize;
      burst_q <= burst_e'(arburst);
    end else if (beat_taken && burst_q == burst_incr) begin
      addr_q <= addr_q + (ADDR_W'(1) << size_q);
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state    <= rd_idle;
      arready  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        rd_idle: begin
          if (ar_fire) begin
            state    <= rd_fetch;
            arready  <= 1'b0;
            beat_cnt <= '0;
          end else begin
            arready <= 1'b1;
          end
        end
        rd_fetch: begin
          // last beat gets its own state so rlast comes straight from it
          state <= (beat_cnt == len_q) ? rd_done : rd_beat;
        end
        rd_beat: begin
          if (rready) begin
            state    <= rd_fetch;
            beat_cnt <= beat_cnt + 8'd1;
          end
        end
        rd_done: begin
          if (rready) begin
            state   <= rd_idle;
            arready <= 1'b1;
          end
        end
        default: begin
          state <= rd_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_ctrl
  import axi_ram_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [ADDR_W-1:0]            awaddr,
  input  logic [ID_W-1:0]              awid,
  input  logic [7:0]                   awlen,
  input  logic [2:0]                   awsize,
  input  logic [1:0]                   awburst,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic [DATA_W-1:0]            wdata,
  input  logic [STRB_W-1:0]            wstrb,
  output logic                         bvalid,
  input  logic                         bready,
  output logic [1:0]                   bresp,
  output logic [ID_W-1:0]              bid,
  output logic [$clog2(MEM_WORDS)-1:0] wr_index,
  output logic [STRB_W-1:0]            lane_we,
  output logic [DATA_W-1:0]            lane_wdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  wr_state_e         state;
  logic [ADDR_W-1:0] addr_q;
  logic [ID_W-1:0]   id_q;
  logic [7:0]        len_q;
  logic [2:0]        size_q;
  burst_e            burst_q;
  logic [7:0]        beat_cnt;
  logic              burst_ok;
  logic              aw_fire;
  logic              w_fire;

  assign aw_fire  = awvalid && awready;
  assign w_fire   = wvalid && wready;
  assign burst_ok = (burst_q == burst_fixed) || (burst_q == burst_incr);

  // bank write port, beat goes in on the same edge it is accepted
  assign wr_index   = addr_q[3 +: IDX_W];
  assign lane_we    = (w_fire && burst_ok) ? wstrb : '0;
  assign lane_wdata = wdata;

  assign bresp = burst_ok ? resp_okay : resp_slverr;
  assign bid   = id_q;

  // request fields and running beat address
  always_ff @(posedge clock) begin
    if (aw_fire) begin
      addr_q  <= awaddr;
      id_q    <= awid;
      len_q   <= awlen;
      size_q  <= awsize;
      burst_q <= burst_e'(awburst);
    end else if (w_fire && burst_q == burst_incr) begin
      addr_q <= addr_q + (ADDR_W'(1) << size_q);  // FIXED keeps its address
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state    <= wr_idle;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        wr_idle: begin
          if (aw_fire) begin
            state    <= wr_data;
            awready  <= 1'b0;
            wready   <= 1'b1;
            beat_cnt <= '0;
          end else begin
            awready <= 1'b1;
          end
        end
        wr_data: begin
          if (w_fire) begin
            // count from awlen, wlast is ignored
            if (beat_cnt == len_q) begin
              state  <= wr_resp;
              wready <= 1'b0;
              bvalid <= 1'b1;
            end else begin
              beat_cnt <= beat_cnt + 8'd1;
            end
          end
        end
        wr_resp: begin
          if (bready) begin
            state   <= wr_idle;
            bvalid  <= 1'b0;
            awready <= 1'b1;
          end
        end
        default: begin
          state <= wr_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/lane_bank.sv
`timescale 1ns/1ps
`default_nettype none

module lane_bank #(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clock,
  input  logic                         we,
  input  logic [$clog2(MEM_WORDS)-1:0] wr_index,
  input  logic [7:0]                   wdata,
  input  logic                         rd_en,
  input  logic [$clog2(MEM_WORDS)-1:0] rd_index,
  output logic [7:0]                   rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [7:0] mem [MEM_WORDS];
  logic [IDX_W-1:0] wr_addr;
  logic [IDX_W-1:0] rd_addr;

  assign wr_addr = wr_index;
  assign rd_addr = rd_index;

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= wdata;
    end
  end

  // held when rd_en is low, so R can stall
  always_ff @(posedge clock) begin
    if (rd_en) begin
      rdata <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the axi_ram testbench with Verilator.
# Exit status is nonzero when the build fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  -f axi_ram.f --top-module axi_ram_tb -o sim_axi_ram > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_axi_ram > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

// File: verif/axi_ram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_tb
  import axi_ram_pkg::*;
();

  localparam int MEM_WORDS   = 64;
  localparam int CYCLE_LIMIT = 60000;  // ~200 bursts of up to 16 beats at under 10 cycles a beat

  logic              clock;
  logic              rst_n;
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic [ID_W-1:0]   awid;
  logic [7:0]        awlen;
  logic [2:0]        awsize;
  logic [1:0]        awburst;
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wlast;
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;
  logic [ID_W-1:0]   bid;
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic [ID_W-1:0]   arid;
  logic [7:0]        arlen;
  logic [2:0]        arsize;
  logic [1:0]        arburst;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rlast;
  logic [ID_W-1:0]   rid;

  integer      seed = 510;
  int          err_cnt = 0;
  int          txn_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] addr;
  logic [7:0]  ref_mem [MEM_WORDS*8];  // byte image indexed by word*8 + lane

  axi_ram_top #(.MEM_WORDS(MEM_WORDS)) axi_ram_top_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awid    (awid),
    .awlen   (awlen),
    .awsize  (awsize),
    .awburst (awburst),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .bid     (bid),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arid    (arid),
    .arlen   (arlen),
    .arsize  (arsize),
    .arburst (arburst),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rid     (rid)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles with %0d errors", cycle_cnt, err_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] beat_addr(input logic [31:0] start, input int beat,
                                            input int size, input logic [1:0] burst);
    if (burst == burst_incr) begin
      return start + 32'(beat) * (32'd1 << size);
    end
    return start;  // FIXED and unsupported stay put
  endfunction

  function automatic int word_index(input logic [31:0] a);
    return int'((a >> 3) % 32'(MEM_WORDS));
  endfunction

  function automatic logic [63:0] expected_word(input int w);
    logic [63:0] v;
    for (int i = 0; i < 8; i++) begin
      v[8*i +: 8] = ref_mem[w*8 + i];
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, act);
    err_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("t=%0t %s", $time, what);
    err_cnt++;
  endtask

  task automatic write_burst(input logic [31:0] start, input logic [3:0] id, input int len,
                             input int size, input logic [1:0] burst, input bit rand_strb);
    logic [31:0] a;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [1:0]  exp_resp;
    bit          supported;
    bit          taken;
    bit          done;
    int          b;
    int          w;
    supported = (burst == burst_fixed) || (burst == burst_incr);
    exp_resp = supported ? resp_okay : resp_slverr;
    txn_cnt++;
    @(negedge clock);
    awvalid = 1'b1;
    awaddr = start;
    awid = id;
    awlen = 8'(len);
    awsize = 3'(size);
    awburst = burst;
    while (!awready) @(negedge clock);
    b = 0;
    taken = 1'b0;
    while (b <= len) begin
      @(negedge clock);
      awvalid = 1'b0;
      if (!wready) report_failure("wready low while write beats remain");
      if (!wvalid || taken) begin
        wvalid = 1'b0;
        if (rand_below(4) != 0) begin  // idle cycles between beats
          data = {rand32(), rand32()};
          strb = rand_strb ? 8'(rand_below(256)) : 8'hff;
          wvalid = 1'b1;
          wdata = data;
          wstrb = strb;
          wlast = (b == len);
        end
      end
      taken = wvalid && wready;
      if (taken) begin
        a = beat_addr(start, b, size, burst);
        w = word_index(a);
        for (int i = 0; i < 8; i++) begin
          if (supported && wstrb[i]) begin
            ref_mem[w*8 + i] = wdata[8*i +: 8];
          end
        end
        b++;
      end
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      wvalid = 1'b0;
      wlast = 1'b0;
      bready = (rand_below(3) == 0);
      if (!bvalid) begin
        report_failure("bvalid low after the last write beat, before bready");
      end else begin
        if (bresp !== exp_resp) report_mismatch("bresp", 64'(exp_resp), 64'(bresp));
        if (bid !== id) report_mismatch("bid", 64'(id), 64'(bid));
        done = bready;
      end
    end
  endtask

  task automatic read_burst(input logic [31:0] start, input logic [3:0] id, input int len,
                            input int size, input logic [1:0] burst);
    logic [63:0] exp_data;
    logic [63:0] held_data;
    logic [3:0]  held_id;
    logic        held_last;
    logic [1:0]  exp_resp;
    bit          supported;
    bit          held;
    int          b;
    int          wait_cnt;
    supported = (burst == burst_fixed) || (burst == burst_incr);
    exp_resp = supported ? resp_okay : resp_slverr;
    txn_cnt++;
    @(negedge clock);
    arvalid = 1'b1;
    araddr = start;
    arid = id;
    arlen = 8'(len);
    arsize = 3'(size);
    arburst = burst;
    while (!arready) @(negedge clock);
    b = 0;
    wait_cnt = 0;
    held = 1'b0;
    while (b <= len) begin
      @(negedge clock);
      arvalid = 1'b0;
      rready = (rand_below(2) == 0);
      wait_cnt++;
      if (!rvalid) begin
        if (held) report_failure("rvalid dropped while the master stalled R");
      end else if (held) begin
        if (rdata !== held_data) report_mismatch("rdata", held_data, rdata);
        if (rid !== held_id) report_mismatch("rid", 64'(held_id), 64'(rid));
        if (rlast !== held_last) report_mismatch("rlast", 64'(held_last), 64'(rlast));
      end else begin
        // new beat due 2 cycles after AR or the previous accepted beat
        if (wait_cnt != 2) report_mismatch("rvalid_latency", 64'd2, 64'(wait_cnt));
        exp_data = supported ? expected_word(word_index(beat_addr(start, b, size, burst)))
                             : 64'd0;
        if (rdata !== exp_data) report_mismatch("rdata", exp_data, rdata);
        if (rresp !== exp_resp) report_mismatch("rresp", 64'(exp_resp), 64'(rresp));
        if (rid !== id) report_mismatch("rid", 64'(id), 64'(rid));
        if (rlast !== (b == len)) report_mismatch("rlast", 64'(b == len), 64'(rlast));
        held_data = rdata;
        held_id = rid;
        held_last = rlast;
      end
      if (rvalid && rready) begin
        b++;
        wait_cnt = 0;
        held = 1'b0;
      end else if (rvalid) begin
        held = 1'b1;
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    awid = '0;
    awlen = '0;
    awsize = '0;
    awburst = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    arid = '0;
    arlen = '0;
    arsize = '0;
    arburst = '0;
    rready = 1'b0;
    repeat (4) begin
      @(negedge clock);
      if (bvalid || rvalid || awready || arready || wready || rlast) begin
        report_failure("valid, ready or rlast output high during reset");
      end
    end
    rst_n = 1'b1;
    @(negedge clock);
    if (!awready || !arready) report_failure("awready or arready low after reset");

    // fill all 64 words
    write_burst(32'h0, 4'(rand_below(16)), 63, 3, burst_incr, 1'b0);

    repeat (40) begin
      write_burst(rand32(), 4'(rand_below(16)), rand_below(16), rand_below(4),
                  burst_incr, 1'b1);
      repeat (2) begin
        read_burst(rand32(), 4'(rand_below(16)), rand_below(16), rand_below(4), burst_incr);
      end
    end

    repeat (15) begin
      addr = rand32();
      write_burst(addr, 4'(rand_below(16)), rand_below(16), rand_below(4),
                  burst_fixed, 1'b1);
      read_burst(addr, 4'(rand_below(16)), rand_below(16), rand_below(4), burst_fixed);
    end

    repeat (10) begin
      addr = rand32();
      write_burst(addr, 4'(rand_below(16)), rand_below(16), 3,
                  (rand_below(2) == 0) ? burst_wrap : burst_rsvd, 1'b1);
      read_burst(addr, 4'(rand_below(16)), 3, 3, burst_incr);  // memory untouched
      read_burst(rand32(), 4'(rand_below(16)), rand_below(16), 2, burst_wrap);
    end

    $display("transactions: %0d errors: %0d", txn_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
